/* sim/exec_testdata.txt */
// Columns in hex: test, kill before send, op (0 add 1 sub 2 and 3 xor 4 mulw 5 mul 6 divuw 7 divu),
// tag, src_a, src_b, expected result
1 0 0 01 0000000000000005 0000000000000003 0000000000000008
1 0 1 02 0000000000000010 0000000000000001 000000000000000F
1 0 2 03 00000000FF00FF00 000000000F0F0F0F 000000000F000F00
1 0 3 04 000000000000AAAA 0000000000005555 000000000000FFFF
1 0 0 05 FFFFFFFFFFFFFFFF 0000000000000001 0000000000000000
1 0 1 06 0000000000000000 0000000000000001 FFFFFFFFFFFFFFFF
2 0 4 10 FFFFFFFF00000003 0000000500000007 0000000000000015
2 0 5 11 0000000100000002 0000000000000003 0000000300000006
2 0 0 12 0000000000000007 0000000000000008 000000000000000F
2 0 4 13 0000000080000000 0000000000000002 0000000000000000
2 0 5 14 FFFFFFFFFFFFFFFF 0000000000000002 FFFFFFFFFFFFFFFE
2 0 3 15 00000000000000F0 000000000000000F 00000000000000FF
2 0 5 16 0000000100000000 0000000100000000 0000000000000000
2 0 4 17 0000000000001234 0000000000000010 0000000000012340
2 0 2 18 000000000000FFFF 00000000000000FF 00000000000000FF
3 0 7 20 0000000000000064 0000000000000007 000000000000000E
3 0 6 21 FFFFFFFF00000064 0000000000000000 FFFFFFFFFFFFFFFF
3 0 7 22 FFFFFFFFFFFFFFFF 0000000000000010 0FFFFFFFFFFFFFFF
3 0 6 23 FFFFFFFF90000000 0000000000000003 0000000030000000
3 0 7 24 0000000000000000 0000000000000005 0000000000000000
4 0 5 30 0000000000000003 0000000000000005 000000000000000F
4 0 0 31 0000000000000001 0000000000000001 0000000000000002
4 0 0 32 0000000000000002 0000000000000002 0000000000000004
4 0 5 33 0000000000000100 0000000000000100 0000000000010000
4 0 1 34 0000000000000009 0000000000000004 0000000000000005
4 0 4 35 00000000FFFFFFFF 00000000FFFFFFFF 0000000000000001
4 0 2 36 000000000000F0F0 000000000000FF00 000000000000F000
4 0 3 37 0000000000000001 0000000000000001 0000000000000000
5 0 7 40 0000000000001000 0000000000000010 0000000000000100
5 0 6 41 0000000000000500 0000000000000005 0000000000000100
5 0 5 42 0000000000000007 0000000000000007 0000000000000031
5 0 0 43 0000000000000001 0000000000000002 0000000000000003
5 1 0 44 000000000000000A 000000000000000B 0000000000000015
5 0 7 45 00000000000000FF 0000000000000003 0000000000000055
5 0 4 46 0000000000000006 0000000000000007 000000000000002A
5 0 1 47 0000000000000020 0000000000000001 000000000000001F

/* flist.f */
+incdir+common
common/exec_pkg.sv
score_board/score_board.sv
hdl/issue_stage.sv
hdl/mul_unit.sv
hdl/div_unit.sv
hdl/writeback_merge.sv
hdl/exec_top.sv
sim/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - include_dirs:
      - common
    files:
      - common/exec_pkg.sv
      - score_board/score_board.sv
      - hdl/issue_stage.sv
      - hdl/mul_unit.sv
      - hdl/div_unit.sv
      - hdl/writeback_merge.sv
      - hdl/exec_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/exec_tb.sv

/* sim/exec_tb.sv */
/*
 * Testbench for the execute stage. Streams the vectors of the test data file
 * through a credit-keeping driver, tracks every tag from send to writeback and
 * checks value, latency, kill behaviour and credit returns.
 */
`timescale 1ns/1ps
`include "exec_defs.svh"

module exec_tb;

    import exec_pkg::*;

    localparam int NCOL  = 7;                               // test, kill, op, tag, a, b, expected
    localparam int MAXV  = 64;
    localparam int NTEST = 5;
    localparam int NTAG  = 2 ** `EXEC_TAG_W;

    logic                    clk_i;
    logic                    rstn_i;
    logic                    kill_i;
    logic                    req_valid_i;
    exec_req_t               req_i;
    logic                    credit_o;
    exec_res_t               res_o;

    logic [63:0]             tv [0:NCOL*MAXV-1];            // Raw vector words
    int                      nvec;
    int                      cyc;
    int                      limit;
    int                      errors;
    int                      nchecks;
    int                      credits;                       // Source side credit counter
    int                      sent_cnt;
    int                      pulse_cnt;
    int                      npend;
    logic [`EXEC_XLEN-1:0]   exp_data [NTAG];
    bit                      pending [NTAG];
    bit                      killed [NTAG];
    int                      issue_cyc [NTAG];
    int                      exp_lat [NTAG];
    logic [`EXEC_TAG_W-1:0]  sent_q [$];                    // Sent but not yet issued, in order

    exec_top u_exec_top (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .kill_i      (kill_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .credit_o    (credit_o),
        .res_o       (res_o)
    );

    always #50 clk_i = ~clk_i;                              // 100 ns period

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
        if (cyc > limit) begin
            $display("timeout: run exceeded %0d cycles with %0d results outstanding",
                     limit, npend);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        nchecks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    // Result rules of the execute stage
    function automatic logic [63:0] model_result(input exec_op_e op, input logic [63:0] a,
                                                 input logic [63:0] b);
        logic [31:0] lo_prod;
        lo_prod = a[31:0] * b[31:0];
        case (op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_and:   return a & b;
            op_xor:   return a ^ b;
            op_mulw:  return {32'h0, lo_prod};
            op_mul:   return a * b;
            op_divuw: return (b[31:0] == 32'h0) ? {64{1'b1}} : {32'h0, a[31:0] / b[31:0]};
            op_divu:  return (b == 64'h0) ? {64{1'b1}} : a / b;
            default:  return 64'h0;
        endcase
    endfunction

    // Issue to res_o.valid, unit latency plus the writeback register
    function automatic int latency_of(input exec_op_e op);
        case (op)
            op_mulw:  return `EXEC_LAT_MULW + 1;
            op_mul:   return `EXEC_LAT_MUL + 1;
            op_divuw: return `EXEC_LAT_DIVW + 1;
            op_divu:  return `EXEC_LAT_DIV + 1;
            default:  return 2;                             // ALU class
        endcase
    endfunction

    task automatic check_result(input logic [`EXEC_TAG_W-1:0] tag,
                                input logic [`EXEC_XLEN-1:0] data);
        if (killed[tag]) begin
            errors++;
            $display("result returned for tag %02h after it was killed", tag);
        end else if (!pending[tag]) begin
            errors++;
            $display("unexpected result for tag %02h, which is not outstanding", tag);
        end else begin
            if (issue_cyc[tag] < 0) begin
                errors++;
                $display("result for tag %02h arrived before any credit showed it issued", tag);
            end else begin
                check_value($sformatf("res_o latency tag %02h", tag), cyc - issue_cyc[tag],
                            exp_lat[tag]);
            end
            check_value($sformatf("res_o.data tag %02h", tag), data, exp_data[tag]);
            pending[tag] = 1'b0;
            npend--;
        end
    endtask

    // Outputs are sampled mid cycle where they are settled
    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (res_o.valid) check_result(res_o.tag, res_o.data);
            if (credit_o) begin
                pulse_cnt++;
                credits++;
                if (credits > `EXEC_QDEPTH) begin
                    errors++;
                    $display("credit count rose above the queue depth");
                end
                if (sent_q.size() == 0) begin
                    errors++;
                    $display("credit pulse with no request waiting in the queue");
                end else begin
                    issue_cyc[sent_q.pop_front()] = cyc;
                end
            end
            if (kill_i) begin                               // Everything still open is dropped
                for (int t = 0; t < NTAG; t++) begin
                    if (pending[t]) begin
                        killed[t]  = 1'b1;
                        pending[t] = 1'b0;
                    end
                end
                npend = 0;
                sent_q.delete();
            end
        end
    end

    task automatic apply_kill();
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        kill_i      <= 1'b1;
        @(posedge clk_i);
        kill_i    <= 1'b0;
        credits   = `EXEC_QDEPTH;                           // Source restarts its credits
        sent_cnt  = 0;
        pulse_cnt = 0;
    endtask

    task automatic send_vector(input int i, input bit gaps);
        int                      gap;
        logic [`EXEC_TAG_W-1:0]  tag;
        exec_op_e                op;
        tag = tv[i*NCOL+3][`EXEC_TAG_W-1:0];
        op  = exec_op_e'(tv[i*NCOL+2][2:0]);
        if (tv[i*NCOL+1] != 64'h0) apply_kill();
        gap = gaps ? int'($urandom % 3) : 0;
        repeat (gap) begin
            @(posedge clk_i);
            req_valid_i <= 1'b0;
        end
        do begin
            @(posedge clk_i);
            req_valid_i <= 1'b0;
        end while (credits == 0);                           // Hold off without credit
        req_valid_i <= 1'b1;
        req_i <= '{op: op, tag: tag, src_a: tv[i*NCOL+4], src_b: tv[i*NCOL+5]};
        credits--;
        sent_cnt++;
        exp_data[tag]  = tv[i*NCOL+6];
        exp_lat[tag]   = latency_of(op);
        issue_cyc[tag] = -1;
        pending[tag]   = 1'b1;
        npend++;
        sent_q.push_back(tag);
    endtask

    task automatic run_test(input int t, input bit gaps);
        int err0;
        int nv;
        err0      = errors;
        nv        = 0;
        sent_cnt  = 0;
        pulse_cnt = 0;
        for (int i = 0; i < nvec; i++) begin
            if (tv[i*NCOL] == t) begin
                send_vector(i, gaps);
                nv++;
            end
        end
        @(posedge clk_i);
        req_valid_i <= 1'b0;
        while (npend != 0) @(posedge clk_i);                // Drain every open tag
        check_value("credit_o pulse count", pulse_cnt, sent_cnt);
        $display("test %0d done: %0d vectors, %0d errors", t, nv, errors - err0);
    endtask

    initial begin
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        kill_i      = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        cyc         = 0;
        errors      = 0;
        nchecks     = 0;
        npend       = 0;
        credits     = `EXEC_QDEPTH;
        for (int i = 0; i < NCOL*MAXV; i++) tv[i] = '1;   // Marks the end of the vectors
        $readmemh("sim/exec_testdata.txt", tv);
        nvec = 0;
        while (nvec < MAXV && tv[nvec*NCOL] != '1) nvec++;
        limit = nvec * 40;
        if (nvec == 0) begin
            errors++;
            $display("no vectors were read from the test data file");
        end
        for (int i = 0; i < nvec; i++) begin                // File values against the model
            check_value($sformatf("testdata expected tag %02h", tv[i*NCOL+3][7:0]),
                        tv[i*NCOL+6],
                        model_result(exec_op_e'(tv[i*NCOL+2][2:0]), tv[i*NCOL+4],
                                     tv[i*NCOL+5]));
        end
        void'($urandom(32'h9d4a_5c50));
        repeat (3) @(posedge clk_i);
        rstn_i <= 1'b1;
        for (int t = 1; t <= NTEST; t++) begin
            run_test(t, (t == 2) || (t == 5));              // Random gaps in mixed and kill runs
        end
        $display("summary: %0d tests, %0d checks, %0d errors", NTEST, nchecks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* hdl/exec_top.sv */
/*
 * Execute stage top. Connects the issue queue, scoreboard, multiplier,
 * the two dividers and the writeback register.
 */
`timescale 1ns/1ps

module exec_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 kill_i,      // Flush queue and all units
    input  logic                 req_valid_i,
    input  exec_pkg::exec_req_t  req_i,
    output logic                 credit_o,
    output exec_pkg::exec_res_t  res_o
);

    import exec_pkg::*;

    logic       set_mulw, set_mul, set_divw, set_div;
    logic       ready_alu, ready_mulw, ready_mul, ready_divw;
    logic       div_unit_sel, div_free;
    logic       mul_start, div0_start, div1_start;
    exec_req_t  mul_req, div0_req, div1_req;
    exec_res_t  alu_res, mul_res, div0_res, div1_res;

    score_board u_score_board (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .kill_i         (kill_i),
        .set_mulw_i     (set_mulw),
        .set_mul_i      (set_mul),
        .set_divw_i     (set_divw),
        .set_div_i      (set_div),
        .ready_alu_o    (ready_alu),
        .ready_mulw_o   (ready_mulw),
        .ready_mul_o    (ready_mul),
        .ready_divw_o   (ready_divw),
        .div_unit_sel_o (div_unit_sel),
        .div_free_o     (div_free)
    );

    issue_stage u_issue_stage (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .kill_i         (kill_i),
        .req_valid_i    (req_valid_i),
        .req_i          (req_i),
        .credit_o       (credit_o),
        .set_mulw_o     (set_mulw),
        .set_mul_o      (set_mul),
        .set_divw_o     (set_divw),
        .set_div_o      (set_div),
        .ready_alu_i    (ready_alu),
        .ready_mulw_i   (ready_mulw),
        .ready_mul_i    (ready_mul),
        .ready_divw_i   (ready_divw),
        .div_unit_sel_i (div_unit_sel),
        .div_free_i     (div_free),
        .mul_req_o      (mul_req),
        .div0_req_o     (div0_req),
        .div1_req_o     (div1_req),
        .mul_start_o    (mul_start),
        .div0_start_o   (div0_start),
        .div1_start_o   (div1_start),
        .alu_res_o      (alu_res)
    );

    mul_unit u_mul_unit (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .kill_i  (kill_i),
        .start_i (mul_start),
        .req_i   (mul_req),
        .res_o   (mul_res)
    );

    div_unit u_div_unit0 (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .kill_i  (kill_i),
        .start_i (div0_start),
        .req_i   (div0_req),
        .res_o   (div0_res)
    );

    div_unit u_div_unit1 (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .kill_i  (kill_i),
        .start_i (div1_start),
        .req_i   (div1_req),
        .res_o   (div1_res)
    );

    writeback_merge u_writeback_merge (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .kill_i     (kill_i),
        .alu_res_i  (alu_res),
        .mul_res_i  (mul_res),
        .div0_res_i (div0_res),
        .div1_res_i (div1_res),
        .res_o      (res_o)
    );

endmodule

/* hdl/writeback_merge.sv */
/*
 * Single writeback port. The scoreboard allows at most one valid source
 * per cycle, so the gated sources are ORed and registered.
 */
`timescale 1ns/1ps
`include "exec_defs.svh"

module writeback_merge (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 kill_i,
    input  exec_pkg::exec_res_t  alu_res_i,
    input  exec_pkg::exec_res_t  mul_res_i,
    input  exec_pkg::exec_res_t  div0_res_i,
    input  exec_pkg::exec_res_t  div1_res_i,
    output exec_pkg::exec_res_t  res_o
);

    import exec_pkg::*;

    exec_res_t               merged;
    logic                    valid_q;
    logic [`EXEC_TAG_W-1:0]  tag_q;
    logic [`EXEC_XLEN-1:0]   data_q;

    // Idle sources may hold stale payload
    function automatic exec_res_t gate(input exec_res_t r);
        return r.valid ? r : '0;
    endfunction

    assign merged = gate(alu_res_i) | gate(mul_res_i) | gate(div0_res_i) | gate(div1_res_i);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= 1'b0;
        end else if (kill_i) begin
            valid_q <= 1'b0;                                // Drop the result in flight
        end else begin
            valid_q <= merged.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (merged.valid) begin
            tag_q  <= merged.tag;
            data_q <= merged.data;
        end
    end

    assign res_o = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

/* hdl/div_unit.sv */
/*
 * Iterative unsigned radix-4 divider, two quotient bits per cycle.
 * divuw takes 16 steps and divu 32; the first step runs on the start edge.
 * A zero divisor returns all ones.
 */
`timescale 1ns/1ps
`include "exec_defs.svh"

module div_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 kill_i,
    input  logic                 start_i,
    input  exec_pkg::exec_req_t  req_i,
    output exec_pkg::exec_res_t  res_o
);

    import exec_pkg::*;

    localparam int W     = `EXEC_XLEN;
    localparam int CNT_W = $clog2(`EXEC_LAT_DIV);

    div_state_e              state_q;
    logic [CNT_W-1:0]        cnt_q;                         // Steps left after this one
    logic                    res_valid_q;
    logic [W-1:0]            rem_q, quo_q, dvs_q;
    logic [`EXEC_TAG_W-1:0]  tag_q;
    logic                    zero_q;
    logic                    is_w;
    logic [W-1:0]            dividend, divisor;

    // One radix-4 step, digit picked by comparing against d, 2d and 3d
    function automatic logic [2*W-1:0] div_step(input logic [W-1:0] rem,
                                                input logic [W-1:0] quo,
                                                input logic [W-1:0] dvs);
        logic [W+2:0] r4;
        logic [W+2:0] d1;
        logic [W+2:0] d2;
        logic [W+2:0] d3;
        logic [W+2:0] diff;
        logic [1:0]   digit;
        r4 = {1'b0, rem, quo[W-1 -: 2]};
        d1 = {3'b000, dvs};
        d2 = {2'b00, dvs, 1'b0};
        d3 = d1 + d2;
        if (r4 >= d3) begin
            digit = 2'd3;
            diff  = r4 - d3;
        end else if (r4 >= d2) begin
            digit = 2'd2;
            diff  = r4 - d2;
        end else if (r4 >= d1) begin
            digit = 2'd1;
            diff  = r4 - d1;
        end else begin
            digit = 2'd0;
            diff  = r4;
        end
        return {diff[W-1:0], quo[W-3:0], digit};
    endfunction

    assign is_w = (req_i.op == op_divuw);
    // Word dividend sits in the top half so its bits are consumed first
    assign dividend = is_w ? {req_i.src_a[W/2-1:0], {(W/2){1'b0}}} : req_i.src_a;
    assign divisor  = is_w ? {{(W/2){1'b0}}, req_i.src_b[W/2-1:0]} : req_i.src_b;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= div_idle;
            cnt_q       <= '0;
            res_valid_q <= 1'b0;
        end else if (kill_i) begin
            state_q     <= div_idle;
            cnt_q       <= '0;
            res_valid_q <= 1'b0;
        end else begin
            res_valid_q <= 1'b0;
            case (state_q)
                div_idle: if (start_i) begin
                    state_q <= div_busy;
                    cnt_q   <= is_w ? CNT_W'(`EXEC_LAT_DIVW - 1) : CNT_W'(`EXEC_LAT_DIV - 1);
                end
                div_busy: begin
                    cnt_q <= cnt_q - 1'b1;
                    if (cnt_q == CNT_W'(1)) begin           // Last step this edge
                        state_q     <= div_idle;
                        res_valid_q <= 1'b1;
                    end
                end
                default: state_q <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i && state_q == div_idle) begin
            {rem_q, quo_q} <= div_step('0, dividend, divisor);
            dvs_q          <= divisor;
            tag_q          <= req_i.tag;
            zero_q         <= (divisor == '0);
        end else if (state_q == div_busy) begin
            {rem_q, quo_q} <= div_step(rem_q, quo_q, dvs_q);
        end
    end

    assign res_o = '{valid: res_valid_q, tag: tag_q, data: zero_q ? {W{1'b1}} : quo_q};

endmodule

/* hdl/mul_unit.sv */
/*
 * Three stage pipelined multiplier. Stage 2 forms the partial products and
 * returns mulw results; stage 3 adds the cross terms for full mul results.
 */
`timescale 1ns/1ps
`include "exec_defs.svh"

module mul_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 kill_i,
    input  logic                 start_i,
    input  exec_pkg::exec_req_t  req_i,
    output exec_pkg::exec_res_t  res_o
);

    import exec_pkg::*;

    localparam int HALF = `EXEC_XLEN / 2;

    logic                    s1_valid_q, s2_valid_q, s3_valid_q;
    logic                    s1_w_q, s2_w_q;                // 32-bit product
    logic [`EXEC_TAG_W-1:0]  s1_tag_q, s2_tag_q, s3_tag_q;
    logic [`EXEC_XLEN-1:0]   s1_a_q, s1_b_q;
    logic [`EXEC_XLEN-1:0]   s2_ll_q;                       // Low x low
    logic [HALF-1:0]         s2_cross_q;                    // Cross terms, low half
    logic [`EXEC_XLEN-1:0]   s3_prod_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            s3_valid_q <= 1'b0;
        end else if (kill_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            s3_valid_q <= 1'b0;
        end else begin
            s1_valid_q <= start_i;
            s2_valid_q <= s1_valid_q;
            s3_valid_q <= s2_valid_q & ~s2_w_q;             // mulw leaves at stage 2
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            s1_w_q   <= (req_i.op == op_mulw);
            s1_tag_q <= req_i.tag;
            s1_a_q   <= req_i.src_a;
            s1_b_q   <= req_i.src_b;
        end
        s2_w_q     <= s1_w_q;
        s2_tag_q   <= s1_tag_q;
        s2_ll_q    <= s1_a_q[HALF-1:0] * s1_b_q[HALF-1:0];
        s2_cross_q <= s1_a_q[HALF-1:0] * s1_b_q[`EXEC_XLEN-1:HALF]
                    + s1_a_q[`EXEC_XLEN-1:HALF] * s1_b_q[HALF-1:0];
        s3_tag_q   <= s2_tag_q;
        s3_prod_q  <= s2_ll_q + {s2_cross_q, {HALF{1'b0}}};
    end

    // Scoreboard keeps stage 2 and stage 3 results from meeting
    always_comb begin
        if (s3_valid_q) begin
            res_o = '{valid: 1'b1, tag: s3_tag_q, data: s3_prod_q};
        end else begin
            res_o = '{valid: s2_valid_q & s2_w_q, tag: s2_tag_q,
                      data: {{HALF{1'b0}}, s2_ll_q[HALF-1:0]}};
        end
    end

endmodule

/* hdl/issue_stage.sv */
/*
 * Credit managed in-order issue queue. The head is sent to its unit once
 * the scoreboard reports its writeback slot free; ALU ops are computed
 * here into a result register.
 */
`timescale 1ns/1ps
`include "exec_defs.svh"

module issue_stage (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 kill_i,
    input  logic                 req_valid_i,
    input  exec_pkg::exec_req_t  req_i,
    output logic                 credit_o,          // One pulse per issued entry

    output logic                 set_mulw_o,
    output logic                 set_mul_o,
    output logic                 set_divw_o,
    output logic                 set_div_o,
    input  logic                 ready_alu_i,
    input  logic                 ready_mulw_i,
    input  logic                 ready_mul_i,
    input  logic                 ready_divw_i,
    input  logic                 div_unit_sel_i,
    input  logic                 div_free_i,

    output exec_pkg::exec_req_t  mul_req_o,
    output exec_pkg::exec_req_t  div0_req_o,
    output exec_pkg::exec_req_t  div1_req_o,
    output logic                 mul_start_o,
    output logic                 div0_start_o,
    output logic                 div1_start_o,
    output exec_pkg::exec_res_t  alu_res_o
);

    import exec_pkg::*;

    localparam int PTR_W = $clog2(`EXEC_QDEPTH);            // Depth is a power of two

    exec_req_t                queue_q [`EXEC_QDEPTH];
    logic [PTR_W-1:0]         wr_ptr_q;
    logic [PTR_W-1:0]         rd_ptr_q;
    logic [PTR_W:0]           count_q;
    exec_req_t                head;
    logic                     head_valid;
    logic                     is_alu, is_mulw, is_mul, is_divw, is_div;
    logic                     class_ready;
    logic                     issue;
    logic [`EXEC_XLEN-1:0]    alu_data;
    logic                     alu_valid_q;
    logic [`EXEC_TAG_W-1:0]   alu_tag_q;
    logic [`EXEC_XLEN-1:0]    alu_data_q;

    assign head       = queue_q[rd_ptr_q];
    assign head_valid = (count_q != '0);

    always_comb begin
        is_alu  = 1'b0;
        is_mulw = 1'b0;
        is_mul  = 1'b0;
        is_divw = 1'b0;
        is_div  = 1'b0;
        case (head.op)
            op_add, op_sub, op_and, op_xor: is_alu = 1'b1;
            op_mulw:  is_mulw = 1'b1;
            op_mul:   is_mul  = 1'b1;
            op_divuw: is_divw = 1'b1;
            op_divu:  is_div  = 1'b1;
            default:  is_alu  = 1'b0;
        endcase
    end

    // Divisions also need an idle divider
    assign class_ready = (is_alu  & ready_alu_i)
                       | (is_mulw & ready_mulw_i)
                       | (is_mul  & ready_mul_i)
                       | (is_divw & ready_divw_i & div_free_i)
                       | (is_div  & div_free_i);

    assign issue    = head_valid & class_ready & ~kill_i;
    assign credit_o = issue;

    assign set_mulw_o   = issue & is_mulw;
    assign set_mul_o    = issue & is_mul;
    assign set_divw_o   = issue & is_divw;
    assign set_div_o    = issue & is_div;
    assign mul_start_o  = issue & (is_mulw | is_mul);
    assign div0_start_o = issue & (is_divw | is_div) & ~div_unit_sel_i;
    assign div1_start_o = issue & (is_divw | is_div) & div_unit_sel_i;
    assign mul_req_o    = head;
    assign div0_req_o   = head;
    assign div1_req_o   = head;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (kill_i) begin
            wr_ptr_q <= '0;                                 // Flush, credits not returned
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (req_valid_i) wr_ptr_q <= wr_ptr_q + 1'b1;   // Credits rule out overflow
            if (issue)       rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({req_valid_i, issue})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && !kill_i) begin
            queue_q[wr_ptr_q] <= req_i;
        end
    end

    always_comb begin
        case (head.op)
            op_add:  alu_data = head.src_a + head.src_b;
            op_sub:  alu_data = head.src_a - head.src_b;
            op_and:  alu_data = head.src_a & head.src_b;
            op_xor:  alu_data = head.src_a ^ head.src_b;
            default: alu_data = '0;                         // Not an ALU op
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            alu_valid_q <= 1'b0;
        end else if (kill_i) begin
            alu_valid_q <= 1'b0;
        end else begin
            alu_valid_q <= issue & is_alu;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue && is_alu) begin
            alu_tag_q  <= head.tag;
            alu_data_q <= alu_data;
        end
    end

    assign alu_res_o = '{valid: alu_valid_q, tag: alu_tag_q, data: alu_data_q};

endmodule

/* score_board/score_board.sv */
/*
 * Writeback slot reservation for the shared result port. Issue only
 * proceeds when the slot of its latency class is free, so unit outputs
 * never collide. Also tracks which of the two dividers is busy.
 */
`timescale 1ns/1ps
`include "exec_defs.svh"

module score_board (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic kill_i,

    input  logic set_mulw_i,        // mulw issued this cycle
    input  logic set_mul_i,         // mul issued this cycle
    input  logic set_divw_i,        // divuw issued this cycle
    input  logic set_div_i,         // divu issued this cycle

    output logic ready_alu_o,       // Slot one cycle ahead is free
    output logic ready_mulw_o,
    output logic ready_mul_o,
    output logic ready_divw_o,
    output logic div_unit_sel_o,    // Divider that takes the next division
    output logic div_free_o         // At least one divider is idle
);

    // Bit k set in cycle c means a unit output is due in cycle c+k+1
    localparam int SLOT_W = `EXEC_LAT_DIV - 1;

    logic [SLOT_W-1:0]        wb_slot_q;
    logic [SLOT_W-1:0]        slot_set;
    logic [SLOT_W-1:0]        occ_set;
    logic [1:0][SLOT_W-1:0]   occ_q;                        // Per divider busy shifter
    logic [1:0]               div_free;

    always_comb begin
        slot_set = '0;
        slot_set[`EXEC_LAT_MULW-2] = set_mulw_i;            // Set at latency distance
        slot_set[`EXEC_LAT_MUL-2]  = set_mul_i;
        slot_set[`EXEC_LAT_DIVW-2] = set_divw_i;
        slot_set[`EXEC_LAT_DIV-2]  = set_div_i;
        occ_set = '0;
        occ_set[`EXEC_LAT_DIVW-2]  = set_divw_i;            // Busy until result cycle
        occ_set[`EXEC_LAT_DIV-2]   = set_div_i;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wb_slot_q <= '0;
            occ_q     <= '0;
        end else if (kill_i) begin
            wb_slot_q <= '0;                                // Nothing left in flight
            occ_q     <= '0;
        end else begin
            wb_slot_q <= (wb_slot_q >> 1) | slot_set;
            for (int u = 0; u < 2; u++) begin
                occ_q[u] <= occ_q[u] >> 1;
            end
            if (div_free[0]) begin
                occ_q[0] <= (occ_q[0] >> 1) | occ_set;      // Divider 0 first
            end else begin
                occ_q[1] <= (occ_q[1] >> 1) | occ_set;
            end
        end
    end

    assign div_free[0] = ~(|occ_q[0]);
    assign div_free[1] = ~(|occ_q[1]);

    // A class of latency L writes back in slot L-1 as seen this cycle
    assign ready_alu_o  = ~wb_slot_q[0];
    assign ready_mulw_o = ~wb_slot_q[`EXEC_LAT_MULW-1];
    assign ready_mul_o  = ~wb_slot_q[`EXEC_LAT_MUL-1];
    assign ready_divw_o = ~wb_slot_q[`EXEC_LAT_DIVW-1];

    // divu has the longest latency, so its slot can only be taken by itself
    // and one issue per cycle keeps that slot free; it needs a divider only
    assign div_unit_sel_o = ~div_free[0];
    assign div_free_o     = |div_free;

endmodule

/* common/exec_pkg.sv */
/*
 * Types shared by the execute stage: opcodes, divider states and the
 * request and result records passed between the units.
 */
`include "exec_defs.svh"

package exec_pkg;

    typedef enum logic [2:0] {
        op_add,     // One-cycle ALU class
        op_sub,
        op_and,
        op_xor,
        op_mulw,    // Low 32 x low 32, zero extended
        op_mul,     // Low 64 bits of the full product
        op_divuw,   // Unsigned 32-bit quotient
        op_divu     // Unsigned 64-bit quotient
    } exec_op_e;

    typedef enum logic {
        div_idle,
        div_busy
    } div_state_e;

    typedef struct packed {
        exec_op_e                op;
        logic [`EXEC_TAG_W-1:0]  tag;
        logic [`EXEC_XLEN-1:0]   src_a;
        logic [`EXEC_XLEN-1:0]   src_b;
    } exec_req_t;

    typedef struct packed {
        logic                    valid;
        logic [`EXEC_TAG_W-1:0]  tag;
        logic [`EXEC_XLEN-1:0]   data;
    } exec_res_t;

endpackage

/* common/exec_defs.svh */
/*
 * Width, depth and latency constants for the execute stage.
 * Included by the package and by every module that sizes logic from them.
 */
`ifndef EXEC_DEFS_SVH
`define EXEC_DEFS_SVH

`define EXEC_XLEN      64  // Operand and result width
`define EXEC_TAG_W     8   // Instruction tag width
`define EXEC_QDEPTH    4   // Issue queue entries, also the credit count

// Issue to unit output latency of the multi-cycle classes
`define EXEC_LAT_MULW  2
`define EXEC_LAT_MUL   3
`define EXEC_LAT_DIVW  16
`define EXEC_LAT_DIV   32

`endif
